// ==== Makefile ====
TOP = dcache_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP) -o $(TOP)

run: compile
	./obj_dir/$(TOP) > run.log 2>&1 || true
	cat run.log
	grep -q "RESULT: PASS" run.log

clean:
	rm -rf obj_dir run.log

// ==== list.f ====
logic/dcache_pkg.sv
logic/dcache_if.sv
logic/dcache_array.sv
logic/dcache_way.sv
logic/dcache_ctrl.sv
logic/dcache_way_select.sv
logic/dcache_top.sv
tb/dcache_checker.sv
tb/dcache_tb.sv

// ==== logic/dcache_array.sv ====
// registered read with no reset, and a read and write of one address at one edge return old data
`timescale 1ns/100ps
`default_nettype none

module dcache_array #(
    parameter int  DEPTH     = 16,
    parameter type payload_t = logic
) (
    input  logic                     clk,
    input  logic                     rd_en_i,
    input  logic [$clog2(DEPTH)-1:0] rd_addr_i,
    input  logic                     wr_en_i,
    input  logic [$clog2(DEPTH)-1:0] wr_addr_i,
    input  payload_t                 wr_data_i,
    output payload_t                 rd_data_o
);

    payload_t mem [DEPTH];
    payload_t rd_data_q;

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
        // output holds between reads
        if (rd_en_i) begin
            rd_data_q <= mem[rd_addr_i];
        end
    end

    assign rd_data_o = rd_data_q;

endmodule

`default_nettype wire

// ==== logic/dcache_ctrl.sv ====
// one request at a time, and memory answers each read strobe once with no back-pressure
`timescale 1ns/100ps
`default_nettype none

module dcache_ctrl #(
    parameter int SET_ASSOC = 4,
    parameter int SET_NUM   = 16
) (
    input  logic               clk,
    input  logic               rst,
    // cpu side
    input  logic               req_valid_i,
    input  logic               req_write_i,
    input  dcache_pkg::addr_t  req_addr_i,
    input  dcache_pkg::word_t  req_wdata_i,
    input  dcache_pkg::be_t    req_be_i,
    output logic               ready_o,
    output logic               resp_valid_o,
    output dcache_pkg::word_t  resp_rdata_o,
    // memory side
    output logic               mem_rd_req_o,
    output logic               mem_wr_req_o,
    output dcache_pkg::addr_t  mem_addr_o,
    output dcache_pkg::line_t  mem_wdata_o,
    input  logic               mem_rd_valid_i,
    input  dcache_pkg::line_t  mem_rdata_i,
    // ways and select
    dcache_way_if.ctrl         way_bus,
    dcache_sel_if.ctrl         sel_bus
);
    import dcache_pkg::*;

    localparam int IDX_W  = $clog2(SET_NUM);
    localparam int TAG_W  = ADDR_WIDTH - IDX_W - LINE_OFFSET_BITS;
    localparam int WAY_W  = $clog2(SET_ASSOC);
    localparam int WSEL_W = LINE_OFFSET_BITS - WORD_OFFSET_BITS;

    typedef enum logic [2:0] {
        ST_SWEEP,
        ST_IDLE,
        ST_LOOKUP,
        ST_WRITEBACK,
        ST_REFILL_WAIT,
        ST_REFILL_WRITE
    } state_t;

    state_t            state_q;
    state_t            state_d;
    logic [IDX_W-1:0]  sweep_cnt_q;
    logic              resp_valid_q;
    logic              rd_req_q;
    logic              wr_req_q;

    // accepted request
    logic              req_write_q;
    addr_t             req_addr_q;
    word_t             req_wdata_q;
    be_t               req_be_q;
    logic [WAY_W-1:0]  victim_q;
    word_t             resp_rdata_q;

    logic              accept;
    logic              miss;
    logic [IDX_W-1:0]  req_index;
    logic [TAG_W-1:0]  req_tag;
    logic [WSEL_W-1:0] req_word;
    line_t             base_line;

    function automatic line_t merge_word(line_t base, logic [WSEL_W-1:0] sel,
                                         word_t wdata, be_t be);
        line_t merged;
        merged = base;
        for (int b = 0; b < WORD_WIDTH / 8; b++) begin
            if (be[b]) begin
                merged[sel][b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        return merged;
    endfunction

    assign accept    = (state_q == ST_IDLE) && req_valid_i;
    assign miss      = (state_q == ST_LOOKUP) && !sel_bus.hit_any;
    assign req_index = req_addr_q[LINE_OFFSET_BITS +: IDX_W];
    assign req_tag   = req_addr_q[ADDR_WIDTH-1 -: TAG_W];
    assign req_word  = req_addr_q[WORD_OFFSET_BITS +: WSEL_W];

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_SWEEP: if (sweep_cnt_q == IDX_W'(SET_NUM - 1)) state_d = ST_IDLE;
            ST_IDLE: if (req_valid_i) state_d = ST_LOOKUP;
            ST_LOOKUP: begin
                if (sel_bus.hit_any) state_d = ST_IDLE;
                else if (sel_bus.victim_dirty) state_d = ST_WRITEBACK;
                else state_d = ST_REFILL_WAIT;
            end
            ST_WRITEBACK: state_d = ST_REFILL_WAIT;
            ST_REFILL_WAIT: if (mem_rd_valid_i) state_d = ST_REFILL_WRITE;
            ST_REFILL_WRITE: state_d = ST_LOOKUP;
            default: state_d = ST_SWEEP;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q      <= ST_SWEEP;
            sweep_cnt_q  <= '0;
            resp_valid_q <= 1'b0;
            rd_req_q     <= 1'b0;
            wr_req_q     <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == ST_SWEEP) begin
                sweep_cnt_q <= sweep_cnt_q + 1'b1;
            end
            resp_valid_q <= (state_q == ST_LOOKUP) && sel_bus.hit_any && !req_write_q;
            // dirty victim goes out first, the read follows a cycle later
            wr_req_q <= miss && sel_bus.victim_dirty;
            rd_req_q <= (miss && !sel_bus.victim_dirty) || (state_q == ST_WRITEBACK);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_write_q <= req_write_i;
            req_addr_q  <= req_addr_i;
            req_wdata_q <= req_wdata_i;
            req_be_q    <= req_be_i;
        end
        if (miss) begin
            victim_q <= sel_bus.victim_way;
        end
        if (state_q == ST_LOOKUP) begin
            resp_rdata_q <= sel_bus.hit_line[req_word];
        end
    end

    // read on accept, and again once the refilled line has landed
    assign way_bus.rd_en    = accept || (state_q == ST_REFILL_WRITE);
    assign way_bus.rd_index = accept ? req_addr_i[LINE_OFFSET_BITS +: IDX_W] : req_index;
    assign way_bus.cmp_tag  = accept ? req_addr_i[ADDR_WIDTH-1 -: TAG_W] : req_tag;

    always_comb begin
        base_line        = (state_q == ST_LOOKUP) ? sel_bus.hit_line : mem_rdata_i;
        way_bus.wr_way   = '0;
        way_bus.wr_index = req_index;
        way_bus.wr_valid = 1'b1;
        way_bus.wr_dirty = req_write_q;
        way_bus.wr_tag   = req_tag;
        way_bus.wr_line  = base_line;
        if (req_write_q) begin
            way_bus.wr_line = merge_word(base_line, req_word, req_wdata_q, req_be_q);
        end
        if (state_q == ST_SWEEP) begin
            // clear one set in all ways per cycle
            way_bus.wr_way   = '1;
            way_bus.wr_index = sweep_cnt_q;
            way_bus.wr_valid = 1'b0;
            way_bus.wr_dirty = 1'b0;
        end else if (state_q == ST_LOOKUP && sel_bus.hit_any && req_write_q) begin
            way_bus.wr_way = SET_ASSOC'(1) << sel_bus.hit_way;
        end else if (state_q == ST_REFILL_WAIT && mem_rd_valid_i) begin
            way_bus.wr_way = SET_ASSOC'(1) << victim_q;
        end
    end

    assign sel_bus.touch       = (state_q == ST_LOOKUP) && sel_bus.hit_any;
    assign sel_bus.touch_index = req_index;
    assign sel_bus.touch_way   = sel_bus.hit_way;

    assign ready_o      = (state_q == ST_IDLE);
    assign resp_valid_o = resp_valid_q;
    assign resp_rdata_o = resp_rdata_q;

    // victim outputs stay put until the next read, so write-back uses them directly
    assign mem_rd_req_o = rd_req_q;
    assign mem_wr_req_o = wr_req_q;
    assign mem_addr_o   = {wr_req_q ? sel_bus.victim_tag : req_tag, req_index,
                           {LINE_OFFSET_BITS{1'b0}}};
    assign mem_wdata_o  = sel_bus.victim_line;

endmodule

`default_nettype wire

// ==== logic/dcache_if.sv ====
// way outputs are packed per way and each way drives only the slice of its own number
`timescale 1ns/100ps
`default_nettype none

interface dcache_way_if #(
    parameter int SET_ASSOC = 4,
    parameter int SET_NUM   = 16
);
    import dcache_pkg::*;

    localparam int IDX_W = $clog2(SET_NUM);
    localparam int TAG_W = ADDR_WIDTH - IDX_W - LINE_OFFSET_BITS;

    // lookup, driven by ctrl
    logic                  rd_en;
    logic [IDX_W-1:0]      rd_index;
    logic [TAG_W-1:0]      cmp_tag;

    // write port, one-hot way select
    logic [SET_ASSOC-1:0]  wr_way;
    logic [IDX_W-1:0]      wr_index;
    logic                  wr_valid;
    logic                  wr_dirty;
    logic [TAG_W-1:0]      wr_tag;
    line_t                 wr_line;

    // per-way results, valid the cycle after rd_en
    logic [SET_ASSOC-1:0]             hit;
    line_t [SET_ASSOC-1:0]            rd_line;
    logic [SET_ASSOC-1:0]             rd_valid;
    logic [SET_ASSOC-1:0]             rd_dirty;
    logic [SET_ASSOC-1:0][TAG_W-1:0]  rd_tag;

    modport ctrl (
        output rd_en, rd_index, cmp_tag,
        output wr_way, wr_index, wr_valid, wr_dirty, wr_tag, wr_line
    );

    modport way (
        input  rd_en, rd_index, cmp_tag,
        input  wr_way, wr_index, wr_valid, wr_dirty, wr_tag, wr_line,
        output hit, rd_line, rd_valid, rd_dirty, rd_tag
    );

    modport select (
        input rd_en, rd_index,
        input hit, rd_line, rd_valid, rd_dirty, rd_tag
    );

endinterface

interface dcache_sel_if #(
    parameter int SET_ASSOC = 4,
    parameter int SET_NUM   = 16
);
    import dcache_pkg::*;

    localparam int IDX_W = $clog2(SET_NUM);
    localparam int TAG_W = ADDR_WIDTH - IDX_W - LINE_OFFSET_BITS;
    localparam int WAY_W = $clog2(SET_ASSOC);

    logic              hit_any;
    logic [WAY_W-1:0]  hit_way;
    line_t             hit_line;

    logic [WAY_W-1:0]  victim_way;
    logic              victim_dirty;
    logic [TAG_W-1:0]  victim_tag;
    line_t             victim_line;

    // pseudo-LRU update, one strobe per finished request
    logic              touch;
    logic [IDX_W-1:0]  touch_index;
    logic [WAY_W-1:0]  touch_way;

    modport select (
        output hit_any, hit_way, hit_line,
        output victim_way, victim_dirty, victim_tag, victim_line,
        input  touch, touch_index, touch_way
    );

    modport ctrl (
        input  hit_any, hit_way, hit_line,
        input  victim_way, victim_dirty, victim_tag, victim_line,
        output touch, touch_index, touch_way
    );

endinterface

`default_nettype wire

// ==== logic/dcache_pkg.sv ====
// a line is four 32-bit words and addresses are 16-bit byte addresses shared by all modules
`default_nettype none

package dcache_pkg;

    localparam int ADDR_WIDTH = 16;
    localparam int WORD_WIDTH = 32;
    localparam int LINE_WORDS = 4;

    // byte within word, byte within line
    localparam int WORD_OFFSET_BITS = 2;
    localparam int LINE_OFFSET_BITS = 4;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [WORD_WIDTH-1:0] word_t;
    typedef logic [WORD_WIDTH/8-1:0] be_t;

    // word 0 sits at the lowest address of the line
    typedef word_t [LINE_WORDS-1:0] line_t;

endpackage

`default_nettype wire

// ==== logic/dcache_top.sv ====
// SET_ASSOC and SET_NUM must be powers of two and ready_o stays low for SET_NUM cycles after reset
`timescale 1ns/100ps
`default_nettype none

module dcache_top #(
    parameter int SET_ASSOC = 4,
    parameter int SET_NUM   = 16
) (
    input  logic               clk,
    input  logic               rst,
    // cpu side
    input  logic               req_valid_i,
    input  logic               req_write_i,
    input  dcache_pkg::addr_t  req_addr_i,
    input  dcache_pkg::word_t  req_wdata_i,
    input  dcache_pkg::be_t    req_be_i,
    output logic               ready_o,
    output logic               resp_valid_o,
    output dcache_pkg::word_t  resp_rdata_o,
    // memory side, line wide
    output logic               mem_rd_req_o,
    output logic               mem_wr_req_o,
    output dcache_pkg::addr_t  mem_addr_o,
    output dcache_pkg::line_t  mem_wdata_o,
    input  logic               mem_rd_valid_i,
    input  dcache_pkg::line_t  mem_rdata_i
);

    dcache_way_if #(.SET_ASSOC(SET_ASSOC), .SET_NUM(SET_NUM)) way_bus ();
    dcache_sel_if #(.SET_ASSOC(SET_ASSOC), .SET_NUM(SET_NUM)) sel_bus ();

    dcache_ctrl #(.SET_ASSOC(SET_ASSOC), .SET_NUM(SET_NUM)) ctrl_i (
        .clk            (clk),
        .rst            (rst),
        .req_valid_i    (req_valid_i),
        .req_write_i    (req_write_i),
        .req_addr_i     (req_addr_i),
        .req_wdata_i    (req_wdata_i),
        .req_be_i       (req_be_i),
        .ready_o        (ready_o),
        .resp_valid_o   (resp_valid_o),
        .resp_rdata_o   (resp_rdata_o),
        .mem_rd_req_o   (mem_rd_req_o),
        .mem_wr_req_o   (mem_wr_req_o),
        .mem_addr_o     (mem_addr_o),
        .mem_wdata_o    (mem_wdata_o),
        .mem_rd_valid_i (mem_rd_valid_i),
        .mem_rdata_i    (mem_rdata_i),
        .way_bus        (way_bus),
        .sel_bus        (sel_bus)
    );

    dcache_way_select #(.SET_ASSOC(SET_ASSOC), .SET_NUM(SET_NUM)) way_select_i (
        .clk     (clk),
        .rst     (rst),
        .way_bus (way_bus),
        .sel_bus (sel_bus)
    );

    for (genvar w = 0; w < SET_ASSOC; w++) begin : g_way
        dcache_way #(.SET_ASSOC(SET_ASSOC), .SET_NUM(SET_NUM), .WAY(w)) way_i (
            .clk     (clk),
            .way_bus (way_bus)
        );
    end

endmodule

`default_nettype wire

// ==== logic/dcache_way.sv ====
// contents are undefined until the reset sweep of the controller has cleared every set
`timescale 1ns/100ps
`default_nettype none

module dcache_way #(
    parameter int SET_ASSOC = 4,
    parameter int SET_NUM   = 16,
    parameter int WAY       = 0
) (
    input logic        clk,
    dcache_way_if.way  way_bus
);
    import dcache_pkg::*;

    localparam int IDX_W = $clog2(SET_NUM);
    localparam int TAG_W = ADDR_WIDTH - IDX_W - LINE_OFFSET_BITS;

    typedef struct packed {
        logic             valid;
        logic             dirty;
        logic [TAG_W-1:0] tag;
    } entry_t;

    entry_t           wr_entry;
    entry_t           rd_entry;
    line_t            rd_line;
    logic [TAG_W-1:0] cmp_tag_q;

    assign wr_entry = '{valid: way_bus.wr_valid, dirty: way_bus.wr_dirty, tag: way_bus.wr_tag};

    dcache_array #(.DEPTH(SET_NUM), .payload_t(entry_t)) tag_array_i (
        .clk       (clk),
        .rd_en_i   (way_bus.rd_en),
        .rd_addr_i (way_bus.rd_index),
        .wr_en_i   (way_bus.wr_way[WAY]),
        .wr_addr_i (way_bus.wr_index),
        .wr_data_i (wr_entry),
        .rd_data_o (rd_entry)
    );

    dcache_array #(.DEPTH(SET_NUM), .payload_t(line_t)) line_array_i (
        .clk       (clk),
        .rd_en_i   (way_bus.rd_en),
        .rd_addr_i (way_bus.rd_index),
        .wr_en_i   (way_bus.wr_way[WAY]),
        .wr_addr_i (way_bus.wr_index),
        .wr_data_i (way_bus.wr_line),
        .rd_data_o (rd_line)
    );

    // tag to compare lines up with the registered entry
    always_ff @(posedge clk) begin
        if (way_bus.rd_en) begin
            cmp_tag_q <= way_bus.cmp_tag;
        end
    end

    assign way_bus.hit[WAY]      = rd_entry.valid && (rd_entry.tag == cmp_tag_q);
    assign way_bus.rd_line[WAY]  = rd_line;
    assign way_bus.rd_valid[WAY] = rd_entry.valid;
    assign way_bus.rd_dirty[WAY] = rd_entry.dirty;
    assign way_bus.rd_tag[WAY]   = rd_entry.tag;

endmodule

`default_nettype wire

// ==== logic/dcache_way_select.sv ====
// SET_ASSOC must be a power of two and at least 2 for the pseudo-LRU tree to be complete
`timescale 1ns/100ps
`default_nettype none

module dcache_way_select #(
    parameter int SET_ASSOC = 4,
    parameter int SET_NUM   = 16
) (
    input logic           clk,
    input logic           rst,
    dcache_way_if.select  way_bus,
    dcache_sel_if.select  sel_bus
);

    localparam int IDX_W = $clog2(SET_NUM);
    localparam int WAY_W = $clog2(SET_ASSOC);

    // one tree per set, node 0 is the root
    logic [SET_NUM-1:0][SET_ASSOC-2:0] plru_q;
    logic [SET_ASSOC-2:0]              plru_set;
    logic [SET_ASSOC-2:0]              plru_upd;
    logic [IDX_W-1:0]                  rd_set_q;
    logic [WAY_W-1:0]                  plru_way;
    logic [WAY_W-1:0]                  free_way;
    logic                              has_free;

    // set whose entries the ways are showing
    always_ff @(posedge clk) begin
        if (way_bus.rd_en) begin
            rd_set_q <= way_bus.rd_index;
        end
    end

    always_comb begin
        sel_bus.hit_way = '0;
        for (int w = 0; w < SET_ASSOC; w++) begin
            if (way_bus.hit[w]) sel_bus.hit_way = WAY_W'(w);
        end
    end

    assign sel_bus.hit_any  = |way_bus.hit;
    assign sel_bus.hit_line = way_bus.rd_line[sel_bus.hit_way];

    // lowest-numbered invalid way wins
    always_comb begin
        has_free = 1'b0;
        free_way = '0;
        for (int w = SET_ASSOC - 1; w >= 0; w--) begin
            if (!way_bus.rd_valid[w]) begin
                has_free = 1'b1;
                free_way = WAY_W'(w);
            end
        end
    end

    assign plru_set = plru_q[rd_set_q];

    // follow the tree bits down to the least recently used leaf
    always_comb begin
        int unsigned node;
        node     = 0;
        plru_way = '0;
        for (int l = 0; l < WAY_W; l++) begin
            plru_way[WAY_W-1-l] = plru_set[node];
            node = 2 * node + 1 + plru_set[node];
        end
    end

    // point every node on the touched path away from it
    always_comb begin
        int unsigned node;
        node     = 0;
        plru_upd = plru_q[sel_bus.touch_index];
        for (int l = 0; l < WAY_W; l++) begin
            plru_upd[node] = !sel_bus.touch_way[WAY_W-1-l];
            node = 2 * node + 1 + sel_bus.touch_way[WAY_W-1-l];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            plru_q <= '0;
        end else if (sel_bus.touch) begin
            plru_q[sel_bus.touch_index] <= plru_upd;
        end
    end

    assign sel_bus.victim_way   = has_free ? free_way : plru_way;
    assign sel_bus.victim_dirty = way_bus.rd_dirty[sel_bus.victim_way];
    assign sel_bus.victim_tag   = way_bus.rd_tag[sel_bus.victim_way];
    assign sel_bus.victim_line  = way_bus.rd_line[sel_bus.victim_way];

endmodule

`default_nettype wire

// ==== tb/dcache_checker.sv ====
// bound to dcache_top and expects SET_NUM to match the bound instance
`timescale 1ns/100ps
`default_nettype none

module dcache_checker #(
    parameter int SET_NUM = 16
) (
    input logic clk,
    input logic rst,
    input logic req_valid_i,
    input logic ready_o,
    input logic resp_valid_o,
    input logic mem_rd_req_o,
    input logic mem_wr_req_o,
    input logic mem_rd_valid_i
);

    localparam int CNT_W = $clog2(SET_NUM) + 1;

    logic [CNT_W-1:0] since_reset_q;
    logic             rd_pending_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            since_reset_q <= '0;
            rd_pending_q  <= 1'b0;
        end else begin
            if (since_reset_q < CNT_W'(SET_NUM)) begin
                since_reset_q <= since_reset_q + 1'b1;
            end
            if (mem_rd_valid_i) begin
                rd_pending_q <= 1'b0;
            end
            if (mem_rd_req_o) begin
                rd_pending_q <= 1'b1;
            end
        end
    end

    strobes_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(mem_rd_req_o && mem_wr_req_o))
        else $error("memory read and write strobes high together");

    // idle and no request means nothing can answer next cycle
    no_stray_response: assert property (@(posedge clk) disable iff (rst)
        (ready_o && !req_valid_i) |=> !resp_valid_o)
        else $error("response without an accepted request");

    single_read: assert property (@(posedge clk) disable iff (rst)
        mem_rd_req_o |-> !rd_pending_q)
        else $error("second memory read before the first was answered");

    sweep_not_ready: assert property (@(posedge clk) disable iff (rst)
        (since_reset_q < CNT_W'(SET_NUM)) |-> !ready_o)
        else $error("ready during the reset sweep");

endmodule

bind dcache_top dcache_checker #(.SET_NUM(SET_NUM)) checker_i (
    .clk            (clk),
    .rst            (rst),
    .req_valid_i    (req_valid_i),
    .ready_o        (ready_o),
    .resp_valid_o   (resp_valid_o),
    .mem_rd_req_o   (mem_rd_req_o),
    .mem_wr_req_o   (mem_wr_req_o),
    .mem_rd_valid_i (mem_rd_valid_i)
);

`default_nettype wire

// ==== tb/dcache_tb.sv ====
// traffic covers 24 lines in 3 sets and the memory model answers each read after 1 to 8 cycles
`timescale 1ns/100ps
`default_nettype none

module dcache_tb;
    import dcache_pkg::*;

    localparam int SET_ASSOC       = 4;
    localparam int SET_NUM         = 16;
    localparam int NUM_RANDOM      = 600;
    localparam int TOTAL_REQ       = NUM_RANDOM + 17;
    localparam int WATCHDOG_CYCLES = TOTAL_REQ * (2 + 2 + 8 + 4) + SET_NUM + 2;
    localparam int POOL_LINES      = 24;
    localparam int MEM_LINES       = 1 << (ADDR_WIDTH - LINE_OFFSET_BITS);
    localparam logic [31:0] LFSR_SEED = 32'h07abdf98;

    logic  clk;
    logic  rst;
    logic  req_valid_i;
    logic  req_write_i;
    addr_t req_addr_i;
    word_t req_wdata_i;
    be_t   req_be_i;
    logic  ready_o;
    logic  resp_valid_o;
    word_t resp_rdata_o;
    logic  mem_rd_req_o;
    logic  mem_wr_req_o;
    addr_t mem_addr_o;
    line_t mem_wdata_o;
    logic  mem_rd_valid_i;
    line_t mem_rdata_i;

    logic [31:0] lfsr_state;
    line_t       mem_lines [MEM_LINES];
    // cpu-visible contents, word granular
    word_t       ref_words [MEM_LINES * LINE_WORDS];
    addr_t       pool [POOL_LINES];

    int   rd_delay;
    int   rd_line_idx;
    int   req_rd_count;
    int   req_wr_count;
    int   wr_total;
    int   last_latency;
    int   requests_done;
    logic load_waiting;

    dcache_top #(.SET_ASSOC(SET_ASSOC), .SET_NUM(SET_NUM)) dcache_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    function automatic line_t ref_line(input addr_t a);
        line_t l;
        for (int w = 0; w < LINE_WORDS; w++) begin
            l[w] = ref_words[(a >> WORD_OFFSET_BITS) + w];
        end
        return l;
    endfunction

    task automatic abort_run();
        $display("RESULT: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        assert (got === exp) else begin
            $display("FAILED %s: expected 0x%0h, got 0x%0h", name, exp, got);
            abort_run();
        end
    endtask

    // one clock, then look at the outputs and serve the memory side
    task automatic step_cycle();
        @(posedge clk);
        #1;
        mem_rd_valid_i = 1'b0;
        if (resp_valid_o) begin
            assert (load_waiting) else begin
                $display("response seen with no load waiting for it");
                abort_run();
            end
            load_waiting = 1'b0;
        end
        if (rd_delay > 0) begin
            rd_delay--;
            if (rd_delay == 0) begin
                mem_rd_valid_i = 1'b1;
                mem_rdata_i    = mem_lines[rd_line_idx];
            end
        end
        if (mem_wr_req_o) begin
            check_value("mem_addr_o[3:0]", mem_addr_o[LINE_OFFSET_BITS-1:0], 0);
            check_value("mem_wdata_o", mem_wdata_o, ref_line(mem_addr_o));
            mem_lines[mem_addr_o >> LINE_OFFSET_BITS] = mem_wdata_o;
            req_wr_count++;
            wr_total++;
        end
        if (mem_rd_req_o) begin
            check_value("mem_addr_o[3:0]", mem_addr_o[LINE_OFFSET_BITS-1:0], 0);
            assert (rd_delay == 0) else begin
                $display("second memory read before the first was answered");
                abort_run();
            end
            rd_line_idx = mem_addr_o >> LINE_OFFSET_BITS;
            rd_delay    = 1 + take_bits(3);
            req_rd_count++;
        end
    endtask

    task automatic do_request(input logic write, input addr_t addr, input word_t wdata,
                              input be_t be);
        word_t expected;
        int    widx;
        widx = addr >> WORD_OFFSET_BITS;
        while (!ready_o) begin
            step_cycle();
        end
        req_valid_i  = 1'b1;
        req_write_i  = write;
        req_addr_i   = addr;
        req_wdata_i  = wdata;
        req_be_i     = be;
        expected     = ref_words[widx];
        if (write) begin
            for (int b = 0; b < WORD_WIDTH / 8; b++) begin
                if (be[b]) begin
                    ref_words[widx][b*8 +: 8] = wdata[b*8 +: 8];
                end
            end
        end
        req_rd_count = 0;
        req_wr_count = 0;
        load_waiting = !write;
        step_cycle();
        last_latency = 1;
        req_valid_i  = 1'b0;
        assert (!ready_o) else begin
            $display("request was not taken while ready was high");
            abort_run();
        end
        if (write) begin
            while (!ready_o) begin
                step_cycle();
                last_latency++;
            end
        end else begin
            while (load_waiting) begin
                step_cycle();
                last_latency++;
            end
            check_value("resp_rdata_o", resp_rdata_o, expected);
        end
        requests_done++;
    endtask

    initial begin
        int          low_cycles;
        int          wr_before;
        int unsigned line_sel;
        int unsigned prev_line;
        logic        write;
        addr_t       addr;
        rst            = 1'b1;
        req_valid_i    = 1'b0;
        req_write_i    = 1'b0;
        req_addr_i     = '0;
        req_wdata_i    = '0;
        req_be_i       = '0;
        mem_rd_valid_i = 1'b0;
        mem_rdata_i    = '0;
        rd_delay       = 0;
        wr_total       = 0;
        requests_done  = 0;
        load_waiting   = 1'b0;
        lfsr_state     = LFSR_SEED;
        for (int i = 0; i < MEM_LINES; i++) begin
            for (int w = 0; w < LINE_WORDS; w++) begin
                mem_lines[i][w]              = take_bits(32);
                ref_words[i * LINE_WORDS + w] = mem_lines[i][w];
            end
        end
        // 8 distinct tags in each of sets 2, 7 and 13
        for (int s = 0; s < 3; s++) begin
            for (int k = 0; k < 8; k++) begin
                pool[s * 8 + k] = {8'(k * 29 + 3), 4'(2 + s * 5 + s / 2), 4'h0};
            end
        end

        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        low_cycles   = 0;
        req_rd_count = 0;
        req_wr_count = 0;
        while (!ready_o && low_cycles <= SET_NUM + 4) begin
            step_cycle();
            low_cycles++;
        end
        check_value("ready_o low cycles", low_cycles, SET_NUM);
        assert (req_rd_count + req_wr_count == 0) else begin
            $display("memory strobe during the reset sweep");
            abort_run();
        end

        do_request(1'b0, pool[0], '0, '0);
        assert (req_rd_count == 1) else begin
            $display("first load after the sweep did not read memory");
            abort_run();
        end

        // more lines than ways in one set, then read them all back
        wr_before = wr_total;
        for (int k = 0; k < 8; k++) begin
            do_request(1'b1, pool[k] | addr_t'((k % 4) * 4), take_bits(32), 4'hf);
        end
        for (int k = 0; k < 8; k++) begin
            do_request(1'b0, pool[k] | addr_t'((k % 4) * 4), '0, '0);
        end
        assert (wr_total > wr_before) else begin
            $display("no dirty line was evicted from the full set");
            abort_run();
        end

        prev_line = 7;
        for (int n = 0; n < NUM_RANDOM; n++) begin
            if (take_bits(2) == 0) begin
                line_sel = prev_line;
            end else begin
                line_sel = take_bits(5) % POOL_LINES;
            end
            addr  = pool[line_sel] | addr_t'(take_bits(2) << WORD_OFFSET_BITS);
            write = 1'(take_bits(1));
            do_request(write, addr, take_bits(32), be_t'(take_bits(4)));
            // same line as the request before must hit
            if (!write && line_sel == prev_line) begin
                assert (req_rd_count + req_wr_count == 0) else begin
                    $display("load to the line just used went to memory");
                    abort_run();
                end
                check_value("load hit latency", last_latency, 2);
            end
            prev_line = line_sel;
        end

        $display("RESULT: PASS");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout with %0d requests completed", requests_done);
        abort_run();
    end

endmodule

`default_nettype wire
